/* common/uart_defines.svh */
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

// Serial bit period in clock cycles, 50 MHz / 115200.
`define UART_CLKS_PER_BIT 434

// Host command, always two bytes.
`define UART_CMD_WIDTH 16

// Receive parity checking, 0 forces the error flag low.
`define UART_PARITY_CHECK 1

`endif

/* common/uart_pkg.sv */
`default_nettype none

`include "uart_defines.svh"

package uart_pkg;

  typedef logic [7:0] uart_byte_t;

  typedef logic [`UART_CMD_WIDTH-1:0] uart_cmd_t;

  // Start bit in bit 0, stop bit in bit 10.
  typedef logic [10:0] uart_frame_t;

  typedef logic [8:0] uart_read_t; // Parity error flag on top.

  typedef logic [$clog2(`UART_CLKS_PER_BIT + 1)-1:0] baud_cnt_t;

  typedef logic [3:0] bit_idx_t;

  typedef enum logic [1:0] {
    IDLE,
    SEND_HI,
    SEND_LO
  } tx_state_t;

endpackage

`default_nettype wire

/* logic/baud_timer.sv */
`default_nettype none

`include "uart_defines.svh"

module baud_timer
  import uart_pkg::*;
(
  input  wire  clk,
  input  wire  rst_n,
  input  wire  run,
  output logic mid_tick,
  output logic bit_tick
);

  localparam baud_cnt_t LAST_CNT = baud_cnt_t'(`UART_CLKS_PER_BIT - 1);
  localparam baud_cnt_t HALF_CNT = baud_cnt_t'(`UART_CLKS_PER_BIT / 2);

  baud_cnt_t cnt;

  // Free running while run is high, parked at zero otherwise.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (!run) begin
      cnt <= '0;
    end else if (cnt == LAST_CNT) begin
      cnt <= '0; // Next bit.
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  assign bit_tick = run && (cnt == LAST_CNT);
  assign mid_tick = run && (cnt == HALF_CNT);

endmodule

`default_nettype wire

/* tx/tx_ctrl_fsm.sv */
`default_nettype none

module tx_ctrl_fsm
  import uart_pkg::*;
(
  input  wire             clk,
  input  wire             rst_n,
  input  wire  uart_cmd_t cmd_in,
  input  wire             cmd_vld,
  input  wire             frame_done,
  output logic            cmd_rdy,
  output logic            load,
  output uart_byte_t      load_byte
);

  tx_state_t state;
  uart_cmd_t cmd_q;
  logic      first_q;
  logic      accept;

  assign accept = (state == IDLE) && cmd_vld && cmd_rdy;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= IDLE;
      cmd_rdy <= 1'b1;
      first_q <= 1'b0;
    end else begin
      first_q <= 1'b0;
      case (state)
        IDLE: begin
          if (accept) begin
            state   <= SEND_HI;
            cmd_rdy <= 1'b0;
            first_q <= 1'b1; // High byte loads on the next cycle.
          end
        end
        SEND_HI: begin
          if (frame_done) begin
            state <= SEND_LO;
          end
        end
        SEND_LO: begin
          if (frame_done) begin
            state   <= IDLE;
            cmd_rdy <= 1'b1;
          end
        end
        default: begin
          state   <= IDLE;
          cmd_rdy <= 1'b1;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q <= cmd_in;
    end
  end

  // Low byte loads on the last tick of the high frame, so the frames
  // run back to back.
  assign load      = first_q || ((state == SEND_HI) && frame_done);
  assign load_byte = first_q ? cmd_q[15:8] : cmd_q[7:0];

endmodule

`default_nettype wire

/* tx/tx_shifter.sv */
`default_nettype none

module tx_shifter
  import uart_pkg::*;
(
  input  wire              clk,
  input  wire              rst_n,
  input  wire              load,
  input  wire  uart_byte_t load_byte,
  input  wire              bit_tick,
  output logic             busy,
  output logic             frame_done,
  output logic             tx
);

  uart_frame_t frame_q;
  uart_frame_t new_frame;
  bit_idx_t    idx;
  logic        shift;

  // Stop, odd parity, data, start.
  assign new_frame = {1'b1, ~^load_byte, load_byte, 1'b0};

  assign shift      = busy && bit_tick;
  assign frame_done = shift && (idx == bit_idx_t'(10));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 1'b0;
      idx  <= '0;
      tx   <= 1'b1;
    end else if (load) begin
      busy <= 1'b1;
      idx  <= '0;
      tx   <= new_frame[0];
    end else if (frame_done) begin
      busy <= 1'b0;
      tx   <= 1'b1; // Line idles high.
    end else if (shift) begin
      idx <= idx + 1'b1;
      tx  <= frame_q[1];
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      frame_q <= new_frame;
    end else if (shift) begin
      frame_q <= {1'b1, frame_q[10:1]};
    end
  end

endmodule

`default_nettype wire

/* rx/rx_deframer.sv */
`default_nettype none

`include "uart_defines.svh"

module rx_deframer
  import uart_pkg::*;
(
  input  wire        clk,
  input  wire        rst_n,
  input  wire        rx,
  input  wire        mid_tick,
  output logic       busy,
  output logic       read_rdy,
  output uart_read_t read_data
);

  typedef enum logic {
    RX_IDLE,
    RX_RECV
  } rx_state_t;

  rx_state_t  state;
  logic       rx_meta;
  logic       rx_sync;
  logic       rx_prev;
  bit_idx_t   idx;
  logic [8:0] sample_q; // Parity and data, LSB first.
  logic       start_edge;
  logic       parity_err;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign start_edge = rx_prev && !rx_sync;
  assign busy       = (state == RX_RECV);

  // Odd parity over data and parity bit.
  assign parity_err = (`UART_PARITY_CHECK != 0) && !(^sample_q);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= RX_IDLE;
      idx       <= '0;
      read_rdy  <= 1'b0;
      read_data <= '0;
    end else begin
      read_rdy <= 1'b0;
      case (state)
        RX_IDLE: begin
          if (start_edge) begin
            state <= RX_RECV;
            idx   <= '0;
          end
        end
        RX_RECV: begin
          if (mid_tick) begin
            if ((idx == '0) && rx_sync) begin
              state <= RX_IDLE; // Glitch, not a start bit.
            end else if (idx == bit_idx_t'(10)) begin
              state <= RX_IDLE;
              // Bad stop bit drops the frame.
              if (rx_sync) begin
                read_rdy  <= 1'b1;
                read_data <= {parity_err, sample_q[7:0]};
              end
            end else begin
              idx <= idx + 1'b1;
            end
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // Data and parity samples only.
  always_ff @(posedge clk) begin
    if (busy && mid_tick && (idx != '0) && (idx != bit_idx_t'(10))) begin
      sample_q <= {rx_sync, sample_q[8:1]};
    end
  end

endmodule

`default_nettype wire

/* logic/uart_cmd_bridge.sv */
`default_nettype none

module uart_cmd_bridge
  import uart_pkg::*;
(
  input  wire             clk,
  input  wire             rst_n,
  input  wire  uart_cmd_t cmd_in,
  input  wire             cmd_vld,
  input  wire             rx,
  output logic            tx,
  output logic            cmd_rdy,
  output logic            read_rdy,
  output uart_read_t      read_data
);

  logic       load;
  uart_byte_t load_byte;
  logic       frame_done;
  logic       tx_busy;
  logic       tx_bit_tick;
  logic       rx_busy;
  logic       rx_mid_tick;

  tx_ctrl_fsm u_tx_ctrl_fsm (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_in     (cmd_in),
    .cmd_vld    (cmd_vld),
    .frame_done (frame_done),
    .cmd_rdy    (cmd_rdy),
    .load       (load),
    .load_byte  (load_byte)
  );

  tx_shifter u_tx_shifter (
    .clk        (clk),
    .rst_n      (rst_n),
    .load       (load),
    .load_byte  (load_byte),
    .bit_tick   (tx_bit_tick),
    .busy       (tx_busy),
    .frame_done (frame_done),
    .tx         (tx)
  );

  // Transmit side only needs the end of each bit.
  baud_timer u_tx_baud (
    .clk      (clk),
    .rst_n    (rst_n),
    .run      (tx_busy),
    .mid_tick (),
    .bit_tick (tx_bit_tick)
  );

  baud_timer u_rx_baud (
    .clk      (clk),
    .rst_n    (rst_n),
    .run      (rx_busy),
    .mid_tick (rx_mid_tick),
    .bit_tick ()
  );

  rx_deframer u_rx_deframer (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .mid_tick  (rx_mid_tick),
    .busy      (rx_busy),
    .read_rdy  (read_rdy),
    .read_data (read_data)
  );

endmodule

`default_nettype wire

/* tb/uart_assertions.sv */
`default_nettype none

module uart_assertions (
  input wire clk,
  input wire rst_n,
  input wire cmd_vld,
  input wire cmd_rdy,
  input wire tx,
  input wire read_rdy
);

  timeunit 1ns;
  timeprecision 1ps;

  // Line must idle high whenever the bridge can take a command.
  tx_idle_high: assert property (
    @(posedge clk) disable iff (!rst_n) cmd_rdy |-> tx
  ) else $error("tx is low while cmd_rdy is high");

  read_rdy_single: assert property (
    @(posedge clk) disable iff (!rst_n) read_rdy |=> !read_rdy
  ) else $error("read_rdy stayed high for two cycles");

  cmd_rdy_drop: assert property ( // Accept edge to falling cmd_rdy.
    @(posedge clk) disable iff (!rst_n) (cmd_vld && cmd_rdy) |=> $fell(cmd_rdy)
  ) else $error("cmd_rdy did not fall one cycle after an accepted command");

endmodule

bind uart_cmd_bridge uart_assertions u_uart_assertions (
  .clk      (clk),
  .rst_n    (rst_n),
  .cmd_vld  (cmd_vld),
  .cmd_rdy  (cmd_rdy),
  .tx       (tx),
  .read_rdy (read_rdy)
);

`default_nettype wire

/* tb/tb_uart_cmd_bridge.sv */
`default_nettype none

`include "uart_defines.svh"

module tb_uart_cmd_bridge
  import uart_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CPB = `UART_CLKS_PER_BIT;
  localparam int NUM_CMDS = 8;
  localparam int NUM_RX = 8;
  localparam int TOTAL_CMDS = NUM_CMDS + 1;
  localparam int TOTAL_RX = NUM_RX + 4;
  localparam int TIMEOUT_CYCLES = (TOTAL_CMDS * 22 + TOTAL_RX * 11 + 200) * CPB;
  localparam int RDY_RETURN = 22 * CPB + 2;
  localparam int POKE_AT = 5 * CPB; // Well inside the high frame.

  logic       clk;
  logic       rst_n;
  uart_cmd_t  cmd_in;
  logic       cmd_vld;
  logic       rx;
  wire        tx;
  wire        cmd_rdy;
  wire        read_rdy;
  uart_read_t read_data;

  uart_frame_t tx_expected[$];
  uart_frame_t tx_seen[$];
  uart_read_t  rx_expected[$];
  int          cycle_count = 0;

  uart_cmd_bridge u_uart_cmd_bridge (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .rx        (rx),
    .tx        (tx),
    .cmd_rdy   (cmd_rdy),
    .read_rdy  (read_rdy),
    .read_data (read_data)
  );

  always #10 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                             input string what);
    if (got !== expected) begin
      abort_run($sformatf("FAILED at %0t: %s, got %0h, expected %0h",
                          $time, what, got, expected));
    end
  endtask

  function automatic uart_frame_t expected_frame(input uart_byte_t data);
    int   ones;
    logic par;
    ones = 0;
    for (int i = 0; i < 8; i++) begin
      ones += data[i];
    end
    par = (ones % 2) == 0; // Total count of ones ends up odd.
    return {1'b1, par, data, 1'b0};
  endfunction

  function automatic uart_read_t expected_read(input uart_byte_t data, input bit corrupt);
    logic flag;
    flag = corrupt && (`UART_PARITY_CHECK != 0);
    return {flag, data};
  endfunction

  // One stray cmd_vld cycle while the bridge is busy.
  task automatic poke_cmd_vld(input uart_cmd_t value);
    @(posedge clk);
    #1;
    cmd_in  = value;
    cmd_vld = 1'b1;
    @(posedge clk);
    #1;
    cmd_vld = 1'b0;
  endtask

  task automatic send_command(input uart_cmd_t cmd, input bit poke_busy);
    int n;
    @(posedge clk);
    #1;
    while (cmd_rdy !== 1'b1) begin
      @(posedge clk);
      #1;
    end
    tx_expected.push_back(expected_frame(cmd[15:8]));
    tx_expected.push_back(expected_frame(cmd[7:0]));
    cmd_in  = cmd;
    cmd_vld = 1'b1;
    @(posedge clk); // Accept edge.
    #1;
    cmd_vld = 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n == 1) begin
        check_value(cmd_rdy, 1'b0, "cmd_rdy after accept");
      end
      if (poke_busy && (n == POKE_AT)) begin
        fork
          poke_cmd_vld(~cmd);
        join_none
      end
    end while (cmd_rdy !== 1'b1);
    check_value(n, RDY_RETURN, "cycles until cmd_rdy returns");
  endtask

  task automatic send_rx_frame(input uart_byte_t data, input bit bad_parity,
                               input bit bad_stop);
    uart_frame_t frame;
    frame = expected_frame(data);
    if (bad_parity) begin
      frame[9] = ~frame[9];
    end
    if (bad_stop) begin
      frame[10] = 1'b0;
    end else begin
      rx_expected.push_back(expected_read(data, bad_parity));
    end
    @(posedge clk);
    #1;
    for (int i = 0; i < 11; i++) begin
      rx = frame[i];
      repeat (CPB) @(posedge clk);
      #1;
    end
    rx = 1'b1; // One idle bit before the next start edge.
    repeat (CPB) @(posedge clk);
  endtask

  task automatic wait_rx_drained();
    while (rx_expected.size() != 0) begin
      @(negedge clk);
    end
  endtask

  initial begin : tx_monitor
    uart_frame_t frame;
    @(posedge rst_n);
    forever begin
      @(negedge tx);
      repeat (CPB / 2) @(negedge clk);
      for (int i = 0; i < 11; i++) begin
        if (i != 0) begin
          repeat (CPB) @(negedge clk);
        end
        frame[i] = tx;
      end
      tx_seen.push_back(frame);
    end
  end

  initial begin : tx_compare
    @(posedge rst_n);
    forever begin
      @(negedge clk);
      if (tx_seen.size() != 0) begin
        if (tx_expected.size() == 0) begin
          abort_run("A frame appeared on tx although no command was pending");
        end else begin
          check_value(tx_seen.pop_front(), tx_expected.pop_front(), "tx frame");
        end
      end
    end
  end

  initial begin : rx_compare
    @(posedge rst_n);
    forever begin
      @(negedge clk);
      if (read_rdy === 1'b1) begin
        if (rx_expected.size() == 0) begin
          abort_run("read_rdy pulsed although no good receive frame was pending");
        end else begin
          check_value(read_data, rx_expected.pop_front(), "read_data");
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count == TIMEOUT_CYCLES) begin
      abort_run($sformatf("Timeout, the run did not finish within %0d cycles", cycle_count));
    end
  end

  initial begin : main
    void'($urandom(32'h3c2d_1a35));
    clk     = 1'b0;
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    rx      = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_value(tx, 1'b1, "tx after reset");
    check_value(cmd_rdy, 1'b1, "cmd_rdy after reset");
    check_value(read_rdy, 1'b0, "read_rdy after reset");
    check_value(read_data, '0, "read_data after reset");

    for (int i = 0; i < NUM_CMDS; i++) begin
      send_command(uart_cmd_t'($urandom), i == 2);
    end

    for (int i = 0; i < NUM_RX; i++) begin
      send_rx_frame(uart_byte_t'($urandom), 1'b0, 1'b0);
    end
    wait_rx_drained();

    // Parity error, then a dropped frame, then a good one.
    send_rx_frame(uart_byte_t'($urandom), 1'b1, 1'b0);
    send_rx_frame(uart_byte_t'($urandom), 1'b0, 1'b1);
    send_rx_frame(uart_byte_t'($urandom), 1'b0, 1'b0);
    wait_rx_drained();

    fork
      send_command(uart_cmd_t'($urandom), 1'b0);
      send_rx_frame(uart_byte_t'($urandom), 1'b0, 1'b0);
    join
    wait_rx_drained();
    repeat (4) @(negedge clk);

    if ((tx_expected.size() != 0) || (tx_seen.size() != 0) || (rx_expected.size() != 0)) begin
      abort_run("Frames were left over at the end of the run");
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* uart_cmd_bridge.f */
+incdir+common
common/uart_pkg.sv
logic/baud_timer.sv
tx/tx_ctrl_fsm.sv
tx/tx_shifter.sv
rx/rx_deframer.sv
logic/uart_cmd_bridge.sv
tb/uart_assertions.sv
tb/tb_uart_cmd_bridge.sv
